/* dispatch_stage.f */
+incdir+src
src/dispatch_pkg.sv
src/lane_payload_if.sv
src/issue_ctrl.sv
src/lane_reg.sv
src/dispatch_stage.sv
verification/tb_dispatch_stage.sv

/* verification/tb_dispatch_stage.sv */
// ####################
// dispatch stage testbench
// directed phases plus a random run against a reference model
// ####################

`timescale 1ns/1ns
`include "dispatch_settings.svh"

module tb_dispatch_stage;
    import dispatch_pkg::*;

    typedef struct packed {
        logic [`INST_ADDR_W-1:0] addr;
        logic                    reg_we;
        logic [`REG_ADDR_W-1:0]  reg_waddr;
        logic [`REG_ADDR_W-1:0]  reg1_raddr;
        logic [`REG_ADDR_W-1:0]  reg2_raddr;
        logic [`IMM_W-1:0]       imm;
        logic [`INST_DATA_W-1:0] inst;
        logic [`COMMIT_ID_W-1:0] commit_id;
    } payload_t;

    localparam int RESET_CYCLES  = 8;
    localparam int RANDOM_CYCLES = 3000;
    localparam int WAIT_LIMIT    = 50;
    localparam logic [31:0] RAND_SEED = 32'h1dd390fb;
    localparam logic [`CU_BUS_W-1:0] FLUSH_MASK = 1 << CU_FLUSH;
    localparam logic [`CU_BUS_W-1:0] STALL_MASK = 1 << CU_STALL_DISPATCH;

    logic                   clk;
    logic                   rst_n;
    logic [`DISP_LANES-1:0] issue;
    logic [`CU_BUS_W-1:0]   stall_flag;
    payload_t               in_pay [`DISP_LANES];
    payload_t               out_pay [`DISP_LANES];
    payload_t               exp_pay [`DISP_LANES];
    logic [`DISP_LANES-1:0] exp_issued;

    logic [`INST_ADDR_W-1:0] o1_addr, o2_addr;
    logic                    o1_reg_we, o2_reg_we;
    logic [`REG_ADDR_W-1:0]  o1_reg_waddr, o2_reg_waddr;
    logic [`REG_ADDR_W-1:0]  o1_reg1_raddr, o2_reg1_raddr;
    logic [`REG_ADDR_W-1:0]  o1_reg2_raddr, o2_reg2_raddr;
    logic [`IMM_W-1:0]       o1_imm, o2_imm;
    logic [`INST_DATA_W-1:0] o1_inst, o2_inst;
    logic [`COMMIT_ID_W-1:0] o1_commit_id, o2_commit_id;

    dispatch_stage DUT (
        .clk                (clk),
        .rst_n              (rst_n),
        .inst1_addr_i       (in_pay[0].addr),
        .inst1_reg_we_i     (in_pay[0].reg_we),
        .inst1_reg_waddr_i  (in_pay[0].reg_waddr),
        .inst1_reg1_raddr_i (in_pay[0].reg1_raddr),
        .inst1_reg2_raddr_i (in_pay[0].reg2_raddr),
        .inst1_imm_i        (in_pay[0].imm),
        .inst1_i            (in_pay[0].inst),
        .inst1_commit_id_i  (in_pay[0].commit_id),
        .inst2_addr_i       (in_pay[1].addr),
        .inst2_reg_we_i     (in_pay[1].reg_we),
        .inst2_reg_waddr_i  (in_pay[1].reg_waddr),
        .inst2_reg1_raddr_i (in_pay[1].reg1_raddr),
        .inst2_reg2_raddr_i (in_pay[1].reg2_raddr),
        .inst2_imm_i        (in_pay[1].imm),
        .inst2_i            (in_pay[1].inst),
        .inst2_commit_id_i  (in_pay[1].commit_id),
        .issue_inst_i       (issue),
        .stall_flag_i       (stall_flag),
        .inst1_addr_o       (o1_addr),
        .inst1_reg_we_o     (o1_reg_we),
        .inst1_reg_waddr_o  (o1_reg_waddr),
        .inst1_reg1_raddr_o (o1_reg1_raddr),
        .inst1_reg2_raddr_o (o1_reg2_raddr),
        .inst1_imm_o        (o1_imm),
        .inst1_o            (o1_inst),
        .inst1_commit_id_o  (o1_commit_id),
        .inst2_addr_o       (o2_addr),
        .inst2_reg_we_o     (o2_reg_we),
        .inst2_reg_waddr_o  (o2_reg_waddr),
        .inst2_reg1_raddr_o (o2_reg1_raddr),
        .inst2_reg2_raddr_o (o2_reg2_raddr),
        .inst2_imm_o        (o2_imm),
        .inst2_o            (o2_inst),
        .inst2_commit_id_o  (o2_commit_id)
    );

    // flat outputs regrouped per lane in struct field order
    always_comb begin
        out_pay[0] = {o1_addr, o1_reg_we, o1_reg_waddr, o1_reg1_raddr,
                      o1_reg2_raddr, o1_imm, o1_inst, o1_commit_id};
        out_pay[1] = {o2_addr, o2_reg_we, o2_reg_waddr, o2_reg1_raddr,
                      o2_reg2_raddr, o2_imm, o2_inst, o2_commit_id};
    end

    initial begin
        clk = 1'b0;
        forever #2 clk = ~clk;
    end

    // expected lane register contents after one edge
    function automatic payload_t next_lane(input payload_t cur, input payload_t din,
                                           input logic issue_bit, input logic flag,
                                           input logic [`CU_BUS_W-1:0] cu);
        payload_t res;
        if (cu[CU_STALL_DISPATCH]) begin
            res = cur;
        end else if (cu[CU_FLUSH] || !issue_bit || flag) begin
            res = '0;
        end else begin
            res = din;
        end
        return res;
    endfunction

    // flush clears even under stall
    function automatic logic next_flag(input logic flag, input logic issue_bit,
                                       input logic [`CU_BUS_W-1:0] cu);
        if (cu[CU_FLUSH]) begin
            return 1'b0;
        end
        if (cu[CU_STALL_DISPATCH]) begin
            return flag;
        end
        return flag | issue_bit;
    endfunction

    function automatic payload_t rand_payload();
        payload_t p;
        p.addr       = `INST_ADDR_W'($urandom);
        p.reg_we     = 1'($urandom);
        p.reg_waddr  = `REG_ADDR_W'($urandom);
        p.reg1_raddr = `REG_ADDR_W'($urandom);
        p.reg2_raddr = `REG_ADDR_W'($urandom);
        p.imm        = `IMM_W'($urandom);
        p.inst       = `INST_DATA_W'($urandom);
        p.commit_id  = `COMMIT_ID_W'($urandom);
        return p;
    endfunction

    task automatic check_value(input string what, input logic [63:0] got,
                               input logic [63:0] exp);
        if (got !== exp) begin
            $display("error: %0t ns: %s mismatch, got %h expected %h", $time, what, got, exp);
            $display("Errors found");
            $fatal(1, "output mismatch");
        end
    endtask

    task automatic check_lane(input int lane);
        check_value($sformatf("lane%0d addr", lane), out_pay[lane].addr, exp_pay[lane].addr);
        check_value($sformatf("lane%0d reg_we", lane), out_pay[lane].reg_we,
                    exp_pay[lane].reg_we);
        check_value($sformatf("lane%0d reg_waddr", lane), out_pay[lane].reg_waddr,
                    exp_pay[lane].reg_waddr);
        check_value($sformatf("lane%0d reg1_raddr", lane), out_pay[lane].reg1_raddr,
                    exp_pay[lane].reg1_raddr);
        check_value($sformatf("lane%0d reg2_raddr", lane), out_pay[lane].reg2_raddr,
                    exp_pay[lane].reg2_raddr);
        check_value($sformatf("lane%0d imm", lane), out_pay[lane].imm, exp_pay[lane].imm);
        check_value($sformatf("lane%0d inst", lane), out_pay[lane].inst, exp_pay[lane].inst);
        check_value($sformatf("lane%0d commit_id", lane), out_pay[lane].commit_id,
                    exp_pay[lane].commit_id);
    endtask

    // model update on the edge and compare once outputs have settled
    initial begin : compare_proc
        forever begin
            @(posedge clk);
            if (!rst_n) begin
                exp_pay[0] = '0;
                exp_pay[1] = '0;
                exp_issued = '0;
            end else begin
                for (int l = 0; l < `DISP_LANES; l++) begin
                    exp_pay[l] = next_lane(exp_pay[l], in_pay[l], issue[l],
                                           exp_issued[l], stall_flag);
                    exp_issued[l] = next_flag(exp_issued[l], issue[l], stall_flag);
                end
            end
            #1;
            for (int l = 0; l < `DISP_LANES; l++) begin
                check_lane(l);
            end
        end
    end

    // one cycle of stimulus with fresh payloads every time
    task automatic drive(input logic [`DISP_LANES-1:0] iss, input logic [`CU_BUS_W-1:0] cu);
        @(negedge clk);
        issue      = iss;
        stall_flag = cu;
        in_pay[0]  = rand_payload();
        in_pay[1]  = rand_payload();
    endtask

    task automatic wait_issued(input logic [`DISP_LANES-1:0] want, input string stage);
        int n;
        n = 0;
        while (exp_issued !== want) begin
            @(negedge clk);
            n++;
            if (n > WAIT_LIMIT) begin
                $display("timeout: issued flags never reached %b during %s", want, stage);
                $display("Errors found");
                $fatal(1, "wait timeout");
            end
        end
    endtask

    initial begin : stimulus
        logic [`CU_BUS_W-1:0] cu;
        void'($urandom(RAND_SEED));
        rst_n      = 1'b0;
        issue      = '0;
        stall_flag = '0;
        in_pay[0]  = '0;
        in_pay[1]  = '0;
        exp_issued = '0;
        for (int i = 0; i < RESET_CYCLES; i++) begin
            @(negedge clk);
        end
        rst_n = 1'b1;

        // idle after reset
        repeat (3) drive(2'b00, '0);
        // first issue on lane 0
        drive(2'b01, '0);
        wait_issued(2'b01, "first issue");
        // lane 0 already issued while lane 1 goes through once
        repeat (3) drive(2'b11, '0);
        wait_issued(2'b11, "second lane issue");

        drive(2'b00, FLUSH_MASK);
        wait_issued(2'b00, "flush");
        drive(2'b01, '0);
        // frozen outputs while other bus bits wiggle
        repeat (4) drive(2'b11, STALL_MASK | `CU_BUS_W'($urandom & 8'hfa));
        drive(2'b10, '0);
        wait_issued(2'b11, "issue after stall");

        // flush inside a stall re-arms without moving outputs
        drive(2'b11, FLUSH_MASK | STALL_MASK);
        wait_issued(2'b00, "flush under stall");
        drive(2'b11, '0);
        drive(2'b11, FLUSH_MASK);
        drive(2'b11, '0);

        for (int i = 0; i < RANDOM_CYCLES; i++) begin
            cu = `CU_BUS_W'($urandom);
            cu[CU_FLUSH] = ($urandom_range(0, 9) == 0);
            cu[CU_STALL_DISPATCH] = ($urandom_range(0, 3) == 0);
            drive(`DISP_LANES'($urandom), cu);
        end

        repeat (2) drive(2'b00, '0);
        @(negedge clk);
        $display("No errors");
        $finish;
    end

endmodule

/* src/dispatch_stage.sv */
// ####################
// dual-issue dispatch register stage
// registers two decoded lanes toward execute
// ####################

`timescale 1ns/1ns
`include "dispatch_settings.svh"

module dispatch_stage (
    input  logic                    clk,
    input  logic                    rst_n,

    // lane 0 from decode
    input  logic [`INST_ADDR_W-1:0] inst1_addr_i,
    input  logic                    inst1_reg_we_i,
    input  logic [`REG_ADDR_W-1:0]  inst1_reg_waddr_i,
    input  logic [`REG_ADDR_W-1:0]  inst1_reg1_raddr_i,
    input  logic [`REG_ADDR_W-1:0]  inst1_reg2_raddr_i,
    input  logic [`IMM_W-1:0]       inst1_imm_i,
    input  logic [`INST_DATA_W-1:0] inst1_i,
    input  logic [`COMMIT_ID_W-1:0] inst1_commit_id_i,

    // lane 1 from decode
    input  logic [`INST_ADDR_W-1:0] inst2_addr_i,
    input  logic                    inst2_reg_we_i,
    input  logic [`REG_ADDR_W-1:0]  inst2_reg_waddr_i,
    input  logic [`REG_ADDR_W-1:0]  inst2_reg1_raddr_i,
    input  logic [`REG_ADDR_W-1:0]  inst2_reg2_raddr_i,
    input  logic [`IMM_W-1:0]       inst2_imm_i,
    input  logic [`INST_DATA_W-1:0] inst2_i,
    input  logic [`COMMIT_ID_W-1:0] inst2_commit_id_i,

    // hazard and pipeline control
    input  logic [`DISP_LANES-1:0]  issue_inst_i,
    input  logic [`CU_BUS_W-1:0]    stall_flag_i,

    // lane 0 to execute
    output logic [`INST_ADDR_W-1:0] inst1_addr_o,
    output logic                    inst1_reg_we_o,
    output logic [`REG_ADDR_W-1:0]  inst1_reg_waddr_o,
    output logic [`REG_ADDR_W-1:0]  inst1_reg1_raddr_o,
    output logic [`REG_ADDR_W-1:0]  inst1_reg2_raddr_o,
    output logic [`IMM_W-1:0]       inst1_imm_o,
    output logic [`INST_DATA_W-1:0] inst1_o,
    output logic [`COMMIT_ID_W-1:0] inst1_commit_id_o,

    // lane 1 to execute
    output logic [`INST_ADDR_W-1:0] inst2_addr_o,
    output logic                    inst2_reg_we_o,
    output logic [`REG_ADDR_W-1:0]  inst2_reg_waddr_o,
    output logic [`REG_ADDR_W-1:0]  inst2_reg1_raddr_o,
    output logic [`REG_ADDR_W-1:0]  inst2_reg2_raddr_o,
    output logic [`IMM_W-1:0]       inst2_imm_o,
    output logic [`INST_DATA_W-1:0] inst2_o,
    output logic [`COMMIT_ID_W-1:0] inst2_commit_id_o
);

    logic [`DISP_LANES-1:0] lane_kill;
    logic                   load_en;

    lane_payload_if lane_in_if[`DISP_LANES] ();
    lane_payload_if lane_out_if[`DISP_LANES] ();

    // flat inputs onto the lane buses
    assign lane_in_if[0].addr       = inst1_addr_i;
    assign lane_in_if[0].reg_we     = inst1_reg_we_i;
    assign lane_in_if[0].reg_waddr  = inst1_reg_waddr_i;
    assign lane_in_if[0].reg1_raddr = inst1_reg1_raddr_i;
    assign lane_in_if[0].reg2_raddr = inst1_reg2_raddr_i;
    assign lane_in_if[0].imm        = inst1_imm_i;
    assign lane_in_if[0].inst       = inst1_i;
    assign lane_in_if[0].commit_id  = inst1_commit_id_i;

    assign lane_in_if[1].addr       = inst2_addr_i;
    assign lane_in_if[1].reg_we     = inst2_reg_we_i;
    assign lane_in_if[1].reg_waddr  = inst2_reg_waddr_i;
    assign lane_in_if[1].reg1_raddr = inst2_reg1_raddr_i;
    assign lane_in_if[1].reg2_raddr = inst2_reg2_raddr_i;
    assign lane_in_if[1].imm        = inst2_imm_i;
    assign lane_in_if[1].inst       = inst2_i;
    assign lane_in_if[1].commit_id  = inst2_commit_id_i;

    issue_ctrl u_issue_ctrl (
        .clk          (clk),
        .rst_n        (rst_n),
        .stall_flag_i (stall_flag_i),
        .issue_inst_i (issue_inst_i),
        .lane_kill_o  (lane_kill),
        .load_en_o    (load_en)
    );

    // one register bank per lane
    for (genvar g = 0; g < `DISP_LANES; g++) begin : g_lane
        lane_reg u_lane_reg (
            .clk       (clk),
            .rst_n     (rst_n),
            .kill_i    (lane_kill[g]),
            .load_en_i (load_en),
            .pay_in    (lane_in_if[g].sink),
            .pay_out   (lane_out_if[g].src)
        );
    end

    // registered lanes back onto flat outputs
    assign inst1_addr_o       = lane_out_if[0].addr;
    assign inst1_reg_we_o     = lane_out_if[0].reg_we;
    assign inst1_reg_waddr_o  = lane_out_if[0].reg_waddr;
    assign inst1_reg1_raddr_o = lane_out_if[0].reg1_raddr;
    assign inst1_reg2_raddr_o = lane_out_if[0].reg2_raddr;
    assign inst1_imm_o        = lane_out_if[0].imm;
    assign inst1_o            = lane_out_if[0].inst;
    assign inst1_commit_id_o  = lane_out_if[0].commit_id;

    assign inst2_addr_o       = lane_out_if[1].addr;
    assign inst2_reg_we_o     = lane_out_if[1].reg_we;
    assign inst2_reg_waddr_o  = lane_out_if[1].reg_waddr;
    assign inst2_reg1_raddr_o = lane_out_if[1].reg1_raddr;
    assign inst2_reg2_raddr_o = lane_out_if[1].reg2_raddr;
    assign inst2_imm_o        = lane_out_if[1].imm;
    assign inst2_o            = lane_out_if[1].inst;
    assign inst2_commit_id_o  = lane_out_if[1].commit_id;

endmodule

/* src/lane_reg.sv */
// ####################
// lane output register bank
// loads payload or zeros, holds under stall
// ####################

`timescale 1ns/1ns
`include "dispatch_settings.svh"

module lane_reg (
    input  logic           clk,
    input  logic           rst_n,
    input  logic           kill_i,
    input  logic           load_en_i,
    lane_payload_if.sink   pay_in,
    lane_payload_if.src    pay_out
);

    logic [`INST_ADDR_W-1:0] addr_q;
    logic                    reg_we_q;
    logic [`REG_ADDR_W-1:0]  reg_waddr_q;
    logic [`REG_ADDR_W-1:0]  reg1_raddr_q;
    logic [`REG_ADDR_W-1:0]  reg2_raddr_q;
    logic [`IMM_W-1:0]       imm_q;
    logic [`INST_DATA_W-1:0] inst_q;
    logic [`COMMIT_ID_W-1:0] commit_id_q;

    // whole bank clears to a bubble on reset
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            addr_q       <= '0;
            reg_we_q     <= 1'b0;
            reg_waddr_q  <= '0;
            reg1_raddr_q <= '0;
            reg2_raddr_q <= '0;
            imm_q        <= '0;
            inst_q       <= '0;
            commit_id_q  <= '0;
        end else if (load_en_i) begin
            // killed lane becomes a bubble
            addr_q       <= kill_i ? '0   : pay_in.addr;
            reg_we_q     <= kill_i ? 1'b0 : pay_in.reg_we;
            reg_waddr_q  <= kill_i ? '0   : pay_in.reg_waddr;
            reg1_raddr_q <= kill_i ? '0   : pay_in.reg1_raddr;
            reg2_raddr_q <= kill_i ? '0   : pay_in.reg2_raddr;
            imm_q        <= kill_i ? '0   : pay_in.imm;
            inst_q       <= kill_i ? '0   : pay_in.inst;
            commit_id_q  <= kill_i ? '0   : pay_in.commit_id;
        end
    end

    assign pay_out.addr       = addr_q;
    assign pay_out.reg_we     = reg_we_q;
    assign pay_out.reg_waddr  = reg_waddr_q;
    assign pay_out.reg1_raddr = reg1_raddr_q;
    assign pay_out.reg2_raddr = reg2_raddr_q;
    assign pay_out.imm        = imm_q;
    assign pay_out.inst       = inst_q;
    assign pay_out.commit_id  = commit_id_q;

    // a killed lane never reaches execute with a register write
    a_kill_no_write : assert property (
        @(posedge clk) disable iff (!rst_n)
        (kill_i && load_en_i) |=> !pay_out.reg_we
    );

endmodule

/* src/issue_ctrl.sv */
// ####################
// dispatch issue controller
// decodes flush and stall, tracks which lanes
// have issued and derives per-lane kill
// ####################

`timescale 1ns/1ns
`include "dispatch_settings.svh"

module issue_ctrl (
    input  logic                   clk,
    input  logic                   rst_n,
    input  logic [`CU_BUS_W-1:0]   stall_flag_i,
    input  logic [`DISP_LANES-1:0] issue_inst_i,
    output logic [`DISP_LANES-1:0] lane_kill_o,
    output logic                   load_en_o
);
    import dispatch_pkg::*;

    logic                   flush;
    logic                   stall;
    logic [`DISP_LANES-1:0] issued_q;

    // control bus decode
    assign flush = stall_flag_i[CU_FLUSH];
    assign stall = stall_flag_i[CU_STALL_DISPATCH];

    // issued flags
    // flush wins over stall so a flushed lane re-arms even while frozen
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            issued_q <= '0;
        end else if (flush) begin
            issued_q <= '0;
        end else if (!stall) begin
            issued_q <= issued_q | issue_inst_i;
        end
    end

    // a lane passes its payload only once per flush window
    assign lane_kill_o = {`DISP_LANES{flush}} | ~issue_inst_i | issued_q;

    // all lane banks share one enable
    assign load_en_o = ~stall;

    // flush leaves every lane re-armed on the following cycle
    a_flush_clears_issued : assert property (
        @(posedge clk) disable iff (!rst_n)
        flush |=> (issued_q == '0)
    );

    // a lane that passes its payload is marked issued at that edge
    a_pass_marks_issued : assert property (
        @(posedge clk) disable iff (!rst_n)
        load_en_o |=> ((issued_q & ~$past(lane_kill_o)) == ~$past(lane_kill_o))
    );

endmodule

/* src/lane_payload_if.sv */
// ####################
// one lane's decoded instruction payload
// ####################

`timescale 1ns/1ns
`include "dispatch_settings.svh"

interface lane_payload_if;

    logic [`INST_ADDR_W-1:0] addr;
    logic                    reg_we;
    logic [`REG_ADDR_W-1:0]  reg_waddr;
    logic [`REG_ADDR_W-1:0]  reg1_raddr;
    logic [`REG_ADDR_W-1:0]  reg2_raddr;
    logic [`IMM_W-1:0]       imm;
    logic [`INST_DATA_W-1:0] inst;
    logic [`COMMIT_ID_W-1:0] commit_id;

    // driving side
    modport src (
        output addr, reg_we, reg_waddr, reg1_raddr, reg2_raddr,
        output imm, inst, commit_id
    );

    // receiving side
    modport sink (
        input addr, reg_we, reg_waddr, reg1_raddr, reg2_raddr,
        input imm, inst, commit_id
    );

endinterface

/* src/dispatch_pkg.sv */
// ####################
// dispatch stage types
// bit positions on the pipeline control bus
// ####################

package dispatch_pkg;

    // only flush and dispatch stall are decoded here
    // the remaining bits belong to other stages
    typedef enum int {
        CU_FLUSH          = 0,
        CU_STALL_DISPATCH = 2
    } cu_bit_e;

endpackage

/* src/dispatch_settings.svh */
// ####################
// dispatch stage widths and sizes
// shared by the RTL and the testbench
// ####################

`ifndef DISPATCH_SETTINGS_SVH
`define DISPATCH_SETTINGS_SVH

// issue lanes
`define DISP_LANES 2

// instruction fields
`define INST_ADDR_W 32
`define INST_DATA_W 32
`define REG_ADDR_W 5
`define IMM_W 32
`define COMMIT_ID_W 3

// pipeline control bus
`define CU_BUS_W 8

`endif
